// ==== cpu_defs.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 6502 core constants
// reset vector, stack page, reset value of S and the bus widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// low byte of the reset vector, high byte follows at +1
`define CPU_RESET_VECTOR 16'hFFFC

// stack lives in page one
`define CPU_STACK_PAGE 8'h01
`define CPU_S_INIT 8'h00

`define CPU_DATA_W 8
`define CPU_ADDR_W 16
`define CPU_TCU_W 3

`endif

// ==== cpu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 6502 core types
// instruction word with its field view, timing counter and opcodes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpu_pkg;

    // classic aaa bbb cc split of an opcode
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } ir_fields_t;

    typedef union packed {
        logic [7:0] op;
        ir_fields_t f;
    } ir_word_t;

    typedef logic [2:0] tcu_t;

    localparam tcu_t T0 = 3'd0;
    localparam tcu_t T1 = 3'd1;
    localparam tcu_t T2 = 3'd2;
    localparam tcu_t T3 = 3'd3;
    localparam tcu_t T4 = 3'd4;
    localparam tcu_t T5 = 3'd5;
    localparam tcu_t T6 = 3'd6;

    // whole opcodes
    localparam logic [7:0] OP_BRK = 8'h00;
    localparam logic [7:0] OP_LDA = 8'hA9;
    localparam logic [7:0] OP_LDX = 8'hA2;
    localparam logic [7:0] OP_LDY = 8'hA0;
    localparam logic [7:0] OP_ORA = 8'h09;
    localparam logic [7:0] OP_AND = 8'h29;
    localparam logic [7:0] OP_EOR = 8'h49;
    localparam logic [7:0] OP_ADD = 8'h69;
    localparam logic [7:0] OP_LSR = 8'h4A;
    localparam logic [7:0] OP_TAX = 8'hAA;
    localparam logic [7:0] OP_TAY = 8'hA8;
    localparam logic [7:0] OP_TXA = 8'h8A;
    localparam logic [7:0] OP_TYA = 8'h98;
    localparam logic [7:0] OP_STA = 8'h8D;
    localparam logic [7:0] OP_STX = 8'h8E;
    localparam logic [7:0] OP_STY = 8'h8C;

    // field view of the cc=01 group
    localparam logic [1:0] CC_ALU  = 2'b01;
    localparam logic [2:0] BBB_IMM = 3'b010;
    localparam logic [2:0] AAA_ORA = 3'b000;
    localparam logic [2:0] AAA_AND = 3'b001;
    localparam logic [2:0] AAA_EOR = 3'b010;
    localparam logic [2:0] AAA_ADD = 3'b011;
    localparam logic [2:0] AAA_LDA = 3'b101;

endpackage

// ==== timing_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing generator
// holds IR and the TCU; reset forces BRK at T2 for the reset sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module timing_gen
    import cpu_pkg::*;
(
    input  logic       i_phi2,
    input  logic       i_rst_n,
    input  logic [7:0] i_data,
    input  tcu_t       i_tcu_next,
    output ir_word_t   o_ir,
    output tcu_t       o_tcu,
    output logic       o_sync
);

    always_ff @(posedge i_phi2)
    begin
        if (!i_rst_n)
        begin
            // reset runs as a forced BRK entered at T2
            o_ir.op <= OP_BRK;
            o_tcu   <= T2;
        end
        else
        begin
            o_tcu <= i_tcu_next;
            // opcode is on the bus during T0
            if (o_tcu == T0)
            begin
                o_ir.op <= i_data;
            end
        end
    end

    assign o_sync = (o_tcu == T0);

endmodule

// ==== decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode ROM
// maps (IR, TCU) onto the next TCU and the datapath and ALU controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cpu_defs.svh"

module decoder
    import cpu_pkg::*;
(
    input  ir_word_t i_ir,
    input  tcu_t     i_tcu,
    output tcu_t     o_tcu,
    output logic     o_rw,
    output logic     o_dl_db, o_dl_adh,
    output logic     o_adl_pcl, o_adh_pch, o_i_pc, o_pcl_adl, o_pch_adh,
    output logic     o_x_sb, o_y_sb, o_ac_sb, o_ac_db, o_x_db, o_y_db,
    output logic     o_s_adl, o_add_sb, o_add_adl,
    output logic     o_0_adl0, o_0_adl1, o_0_adh1_7, o_ff_adh,
    output logic     o_sb_x, o_sb_y, o_sb_ac, o_sb_s,
    output logic     o_adl_abl, o_adh_abh,
    output logic     o_db_add, o_adl_add, o_0_add, o_sb_add, o_ff_add,
    output logic     o_sums, o_ands, o_eors, o_ors, o_srs
);

    logic imm_grp;

    // immediate members of the cc=01 group this core supports
    assign imm_grp = (i_ir.f.cc == CC_ALU) && (i_ir.f.bbb == BBB_IMM)
                     && (i_ir.f.aaa inside {AAA_ORA, AAA_AND, AAA_EOR, AAA_ADD, AAA_LDA});

    always_comb
    begin
        o_tcu      = tcu_t'(i_tcu + `CPU_TCU_W'(1));
        o_rw       = 1'b1;
        o_dl_db    = 1'b0;
        o_dl_adh   = 1'b0;
        o_adl_pcl  = 1'b0;
        o_adh_pch  = 1'b0;
        o_i_pc     = 1'b0;
        o_pcl_adl  = 1'b0;
        o_pch_adh  = 1'b0;
        o_x_sb     = 1'b0;
        o_y_sb     = 1'b0;
        o_ac_sb    = 1'b0;
        o_ac_db    = 1'b0;
        o_x_db     = 1'b0;
        o_y_db     = 1'b0;
        o_s_adl    = 1'b0;
        o_add_sb   = 1'b0;
        o_add_adl  = 1'b0;
        o_0_adl0   = 1'b0;
        o_0_adl1   = 1'b0;
        o_0_adh1_7 = 1'b0;
        o_ff_adh   = 1'b0;
        o_sb_x     = 1'b0;
        o_sb_y     = 1'b0;
        o_sb_ac    = 1'b0;
        o_sb_s     = 1'b0;
        o_adl_abl  = 1'b0;
        o_adh_abh  = 1'b0;
        o_db_add   = 1'b0;
        o_adl_add  = 1'b0;
        o_0_add    = 1'b0;
        o_sb_add   = 1'b0;
        o_ff_add   = 1'b0;
        o_sums     = 1'b0;
        o_ands     = 1'b0;
        o_eors     = 1'b0;
        o_ors      = 1'b0;
        o_srs      = 1'b0;

        case (i_tcu)
        T0:
        begin
            // opcode fetch, the previous IR finishes its write here
            o_i_pc    = 1'b1;
            o_adl_abl = 1'b1;
            o_adh_abh = 1'b1;
            if (i_ir.op == OP_BRK)
            begin
                // vector {DL, ADD} goes out and into PC at once
                o_add_adl = 1'b1;
                o_dl_adh  = 1'b1;
                o_adl_pcl = 1'b1;
                o_adh_pch = 1'b1;
            end
            else
            begin
                o_pcl_adl = 1'b1;
                o_pch_adh = 1'b1;
                case (i_ir.op)
                OP_LDX, OP_TAX:
                begin
                    o_add_sb = 1'b1;
                    o_sb_x   = 1'b1;
                end
                OP_LDY, OP_TAY:
                begin
                    o_add_sb = 1'b1;
                    o_sb_y   = 1'b1;
                end
                OP_LSR, OP_TXA, OP_TYA:
                begin
                    o_add_sb = 1'b1;
                    o_sb_ac  = 1'b1;
                end
                default:
                begin
                    o_add_sb = imm_grp;
                    o_sb_ac  = imm_grp;
                end
                endcase
            end
        end
        T1:
        begin
            o_pcl_adl = 1'b1;
            o_pch_adh = 1'b1;
            o_adl_abl = 1'b1;
            o_adh_abh = 1'b1;
            case (i_ir.op)
            OP_LDX, OP_LDY, OP_STA, OP_STX, OP_STY:
            begin
                // operand byte straight through the adder
                o_i_pc   = 1'b1;
                o_dl_db  = 1'b1;
                o_db_add = 1'b1;
                o_sums   = 1'b1;
                if (i_ir.op == OP_LDX || i_ir.op == OP_LDY)
                begin
                    o_tcu = T0;
                end
            end
            OP_LSR:
            begin
                o_ac_sb  = 1'b1;
                o_sb_add = 1'b1;
                o_0_add  = 1'b1;
                o_srs    = 1'b1;
                o_tcu    = T0;
            end
            OP_TAX, OP_TAY, OP_TXA, OP_TYA:
            begin
                // dummy read, source plus zero
                o_ac_sb  = (i_ir.op == OP_TAX) || (i_ir.op == OP_TAY);
                o_x_sb   = (i_ir.op == OP_TXA);
                o_y_sb   = (i_ir.op == OP_TYA);
                o_sb_add = 1'b1;
                o_0_add  = 1'b1;
                o_sums   = 1'b1;
                o_tcu    = T0;
            end
            default:
            begin
                if (imm_grp)
                begin
                    o_i_pc   = 1'b1;
                    o_dl_db  = 1'b1;
                    o_db_add = 1'b1;
                    o_tcu    = T0;
                    // LDA leaves AI at zero
                    o_ac_sb  = (i_ir.f.aaa != AAA_LDA);
                    o_sb_add = (i_ir.f.aaa != AAA_LDA);
                    case (i_ir.f.aaa)
                    AAA_ORA: o_ors  = 1'b1;
                    AAA_AND: o_ands = 1'b1;
                    AAA_EOR: o_eors = 1'b1;
                    default: o_sums = 1'b1;
                    endcase
                end
            end
            endcase
        end
        T2:
        begin
            case (i_ir.op)
            OP_BRK:
            begin
                // dummy stack read at S, start S-1 in the ALU
                o_s_adl    = 1'b1;
                o_adl_abl  = 1'b1;
                o_0_adh1_7 = 1'b1;
                o_adh_abh  = 1'b1;
                o_adl_add  = 1'b1;
                o_ff_add   = 1'b1;
                o_sums     = 1'b1;
            end
            OP_STA, OP_STX, OP_STY:
            begin
                // high address byte lands in DL
                o_pcl_adl = 1'b1;
                o_pch_adh = 1'b1;
                o_adl_abl = 1'b1;
                o_adh_abh = 1'b1;
                o_i_pc    = 1'b1;
            end
            default:
            begin
                o_tcu = T0;
            end
            endcase
        end
        T3:
        begin
            o_add_adl = 1'b1;
            o_adl_abl = 1'b1;
            o_adh_abh = 1'b1;
            if (i_ir.op == OP_BRK)
            begin
                o_0_adh1_7 = 1'b1;
                o_adl_add  = 1'b1;
                o_ff_add   = 1'b1;
                o_sums     = 1'b1;
            end
            else
            begin
                // write the register at {DL, ADD}
                o_dl_adh = 1'b1;
                o_rw     = 1'b0;
                o_ac_db  = (i_ir.op == OP_STA);
                o_x_db   = (i_ir.op == OP_STX);
                o_y_db   = (i_ir.op == OP_STY);
                o_tcu    = T0;
            end
        end
        T4:
        begin
            // third stack read, ALU runs S-3
            o_add_adl  = 1'b1;
            o_adl_abl  = 1'b1;
            o_0_adh1_7 = 1'b1;
            o_adh_abh  = 1'b1;
            o_adl_add  = 1'b1;
            o_ff_add   = 1'b1;
            o_sums     = 1'b1;
        end
        T5:
        begin
            // read FFFC, S takes S-3, low vector byte into ADD
            o_0_adl0  = 1'b1;
            o_0_adl1  = 1'b1;
            o_adl_abl = 1'b1;
            o_ff_adh  = 1'b1;
            o_adh_abh = 1'b1;
            o_add_sb  = 1'b1;
            o_sb_s    = 1'b1;
            o_dl_db   = 1'b1;
            o_db_add  = 1'b1;
            o_sums    = 1'b1;
        end
        T6:
        begin
            // read FFFD, high byte stays in DL for T0
            o_0_adl1  = 1'b1;
            o_adl_abl = 1'b1;
            o_ff_adh  = 1'b1;
            o_adh_abh = 1'b1;
            o_tcu     = T0;
        end
        default:
        begin
            o_tcu = T0;
        end
        endcase
    end

endmodule

// ==== datapath.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 6502 datapath
// registers, data latch, SB/DB/ADL/ADH buses and the address latches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cpu_defs.svh"

module datapath (
    input  logic                   i_phi2,
    input  logic                   i_rst_n,
    input  logic [`CPU_DATA_W-1:0] i_data,
    input  logic [`CPU_DATA_W-1:0] i_add,
    input  logic                   i_dl_db, i_dl_adh,
    input  logic                   i_adl_pcl, i_adh_pch, i_i_pc, i_pcl_adl, i_pch_adh,
    input  logic                   i_x_sb, i_y_sb, i_ac_sb, i_ac_db, i_x_db, i_y_db,
    input  logic                   i_s_adl, i_add_sb, i_add_adl,
    input  logic                   i_0_adl0, i_0_adl1, i_0_adh1_7, i_ff_adh,
    input  logic                   i_sb_x, i_sb_y, i_sb_ac, i_sb_s,
    input  logic                   i_adl_abl, i_adh_abh,
    output logic [`CPU_DATA_W-1:0] o_sb,
    output logic [`CPU_DATA_W-1:0] o_db,
    output logic [`CPU_DATA_W-1:0] o_adl,
    output logic [`CPU_ADDR_W-1:0] o_addr,
    output logic [`CPU_DATA_W-1:0] o_data
);

    localparam logic [`CPU_ADDR_W-1:0] RESET_VEC = `CPU_RESET_VECTOR;

    logic [`CPU_DATA_W-1:0] pcl, pch, s, ac, x, y, dl, abl, abh;
    logic [`CPU_DATA_W-1:0] adh, adl_const;
    logic [`CPU_ADDR_W-1:0] pc_base;

    // vector low byte, bit 0 released for the FFFD read
    assign adl_const = {RESET_VEC[7:2], RESET_VEC[1] | ~i_0_adl1, RESET_VEC[0] | ~i_0_adl0};

    // buses read zero when nothing drives them
    assign o_sb = ({`CPU_DATA_W{i_x_sb}} & x)
                | ({`CPU_DATA_W{i_y_sb}} & y)
                | ({`CPU_DATA_W{i_ac_sb}} & ac)
                | ({`CPU_DATA_W{i_add_sb}} & i_add);

    // dl_db passes the incoming byte, DL is transparent while phi2 is high
    assign o_db = ({`CPU_DATA_W{i_dl_db}} & i_data)
                | ({`CPU_DATA_W{i_ac_db}} & ac)
                | ({`CPU_DATA_W{i_x_db}} & x)
                | ({`CPU_DATA_W{i_y_db}} & y);

    assign o_adl = ({`CPU_DATA_W{i_pcl_adl}} & pcl)
                 | ({`CPU_DATA_W{i_s_adl}} & s)
                 | ({`CPU_DATA_W{i_add_adl}} & i_add)
                 | ({`CPU_DATA_W{i_0_adl0 | i_0_adl1}} & adl_const);

    assign adh = ({`CPU_DATA_W{i_pch_adh}} & pch)
               | ({`CPU_DATA_W{i_dl_adh}} & dl)
               | ({`CPU_DATA_W{i_0_adh1_7}} & `CPU_STACK_PAGE)
               | ({`CPU_DATA_W{i_ff_adh}} & 8'hFF);

    // PC reloads from the address buses before the increment
    assign pc_base = {i_adh_pch ? adh : pch, i_adl_pcl ? o_adl : pcl};

    always_ff @(posedge i_phi2)
    begin
        if (!i_rst_n)
        begin
            {pch, pcl} <= '0;
            s   <= `CPU_S_INIT;
            ac  <= '0;
            x   <= '0;
            y   <= '0;
            abl <= '0;
            abh <= '0;
        end
        else
        begin
            {pch, pcl} <= pc_base + `CPU_ADDR_W'(i_i_pc);
            if (i_sb_s)
                s <= o_sb;
            if (i_sb_ac)
                ac <= o_sb;
            if (i_sb_x)
                x <= o_sb;
            if (i_sb_y)
                y <= o_sb;
            if (i_adl_abl)
                abl <= o_adl;
            if (i_adh_abh)
                abh <= adh;
        end
    end

    // data latch takes every bus byte
    always_ff @(posedge i_phi2)
    begin
        dl <= i_data;
    end

    // address latches pass through in the cycle they load
    assign o_addr = {i_adh_abh ? adh : abh, i_adl_abl ? o_adl : abl};
    assign o_data = o_db;

endmodule

// ==== alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 6502 ALU
// AI/BI input selects, five operations and the ADD holding register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module alu (
    input  logic       i_phi2,
    input  logic       i_rst_n,
    input  logic [7:0] i_sb,
    input  logic [7:0] i_db,
    input  logic [7:0] i_adl,
    input  logic       i_db_add, i_adl_add, i_0_add, i_sb_add, i_ff_add,
    input  logic       i_sums, i_ands, i_eors, i_ors, i_srs,
    output logic [7:0] o_add
);

    logic [7:0] ai, bi, result;

    always_comb
    begin
        // ff_add stands for the precharged AI reading as minus one
        if (i_ff_add)
            ai = 8'hFF;
        else if (i_sb_add)
            ai = i_sb;
        else
            ai = '0;

        if (i_0_add)
            bi = '0;
        else if (i_db_add)
            bi = i_db;
        else if (i_adl_add)
            bi = i_adl;
        else
            bi = '0;

        // no carry in this core
        if (i_sums)
            result = ai + bi;
        else if (i_ands)
            result = ai & bi;
        else if (i_eors)
            result = ai ^ bi;
        else if (i_ors)
            result = ai | bi;
        else if (i_srs)
            result = {1'b0, ai[7:1]};
        else
            result = o_add;
    end

    always_ff @(posedge i_phi2)
    begin
        if (!i_rst_n)
            o_add <= '0;
        else
            o_add <= result;
    end

endmodule

// ==== cpu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reduced 6502 core
// timing generator, decode ROM, datapath and ALU on one phi2 clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic        i_phi2,
    input  logic        i_rst_n,
    input  logic [7:0]  i_data,
    output logic [15:0] o_addr,
    output logic [7:0]  o_data,
    output logic        o_rw,
    output logic        o_sync
);

    ir_word_t   ir;
    tcu_t       tcu, tcu_next;
    logic [7:0] sb, db, adl, add;

    logic dl_db, dl_adh, adl_pcl, adh_pch, i_pc, pcl_adl, pch_adh;
    logic x_sb, y_sb, ac_sb, ac_db, x_db, y_db, s_adl, add_sb, add_adl;
    logic zero_adl0, zero_adl1, zero_adh1_7, ff_adh;
    logic sb_x, sb_y, sb_ac, sb_s, adl_abl, adh_abh;
    logic db_add, adl_add, zero_add, sb_add, ff_add;
    logic sums, ands, eors, ors, srs;

    timing_gen u_timing (
        .i_phi2     (i_phi2),
        .i_rst_n    (i_rst_n),
        .i_data     (i_data),
        .i_tcu_next (tcu_next),
        .o_ir       (ir),
        .o_tcu      (tcu),
        .o_sync     (o_sync)
    );

    decoder u_decoder (
        .i_ir       (ir),
        .i_tcu      (tcu),
        .o_tcu      (tcu_next),
        .o_rw       (o_rw),
        .o_dl_db    (dl_db),     .o_dl_adh   (dl_adh),
        .o_adl_pcl  (adl_pcl),   .o_adh_pch  (adh_pch),   .o_i_pc   (i_pc),
        .o_pcl_adl  (pcl_adl),   .o_pch_adh  (pch_adh),
        .o_x_sb     (x_sb),      .o_y_sb     (y_sb),      .o_ac_sb  (ac_sb),
        .o_ac_db    (ac_db),     .o_x_db     (x_db),      .o_y_db   (y_db),
        .o_s_adl    (s_adl),     .o_add_sb   (add_sb),    .o_add_adl (add_adl),
        .o_0_adl0   (zero_adl0), .o_0_adl1   (zero_adl1),
        .o_0_adh1_7 (zero_adh1_7), .o_ff_adh (ff_adh),
        .o_sb_x     (sb_x),      .o_sb_y     (sb_y),      .o_sb_ac  (sb_ac),
        .o_sb_s     (sb_s),      .o_adl_abl  (adl_abl),   .o_adh_abh (adh_abh),
        .o_db_add   (db_add),    .o_adl_add  (adl_add),   .o_0_add  (zero_add),
        .o_sb_add   (sb_add),    .o_ff_add   (ff_add),
        .o_sums     (sums),      .o_ands     (ands),      .o_eors   (eors),
        .o_ors      (ors),       .o_srs      (srs)
    );

    datapath u_datapath (
        .i_phi2     (i_phi2),
        .i_rst_n    (i_rst_n),
        .i_data     (i_data),
        .i_add      (add),
        .i_dl_db    (dl_db),     .i_dl_adh   (dl_adh),
        .i_adl_pcl  (adl_pcl),   .i_adh_pch  (adh_pch),   .i_i_pc   (i_pc),
        .i_pcl_adl  (pcl_adl),   .i_pch_adh  (pch_adh),
        .i_x_sb     (x_sb),      .i_y_sb     (y_sb),      .i_ac_sb  (ac_sb),
        .i_ac_db    (ac_db),     .i_x_db     (x_db),      .i_y_db   (y_db),
        .i_s_adl    (s_adl),     .i_add_sb   (add_sb),    .i_add_adl (add_adl),
        .i_0_adl0   (zero_adl0), .i_0_adl1   (zero_adl1),
        .i_0_adh1_7 (zero_adh1_7), .i_ff_adh (ff_adh),
        .i_sb_x     (sb_x),      .i_sb_y     (sb_y),      .i_sb_ac  (sb_ac),
        .i_sb_s     (sb_s),      .i_adl_abl  (adl_abl),   .i_adh_abh (adh_abh),
        .o_sb       (sb),
        .o_db       (db),
        .o_adl      (adl),
        .o_addr     (o_addr),
        .o_data     (o_data)
    );

    alu u_alu (
        .i_phi2     (i_phi2),
        .i_rst_n    (i_rst_n),
        .i_sb       (sb),
        .i_db       (db),
        .i_adl      (adl),
        .i_db_add   (db_add),    .i_adl_add  (adl_add),   .i_0_add  (zero_add),
        .i_sb_add   (sb_add),    .i_ff_add   (ff_add),
        .i_sums     (sums),      .i_ands     (ands),      .i_eors   (eors),
        .i_ors      (ors),       .i_srs      (srs),
        .o_add      (add)
    );

endmodule

// ==== tb_cpu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the reduced 6502 core
// random program from an LCG checked cycle by cycle against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cpu_defs.svh"

module tb_cpu;

    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 60;
    localparam int N_PROG       = N_RANDOM + 4;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 5 + N_RANDOM * 4 + 3 * 4 + 50;
    localparam logic [15:0] PROG_BASE = 16'h0200;

    logic        phi2;
    logic        rst_n;
    logic [7:0]  rd_data;
    logic [15:0] addr;
    logic [7:0]  wr_data;
    logic        rw;
    logic        sync;

    logic [7:0]  mem [0:65535];
    logic [7:0]  prog_op [N_PROG];
    logic [7:0]  prog_lo [N_PROG];
    logic [7:0]  prog_hi [N_PROG];
    logic [31:0] lcg_state;

    // reference model state
    logic [15:0] m_pc;
    logic [7:0]  m_ac;
    logic [7:0]  m_x;
    logic [7:0]  m_y;

    int cycle_count;
    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;

    cpu_top u_dut (
        .i_phi2  (phi2),
        .i_rst_n (rst_n),
        .i_data  (rd_data),
        .o_addr  (addr),
        .o_data  (wr_data),
        .o_rw    (rw),
        .o_sync  (sync)
    );

    // memory answers reads in the same cycle
    assign rd_data = mem[addr];

    always @(posedge phi2)
    begin
        if (rw === 1'b0)
            mem[addr] <= wr_data;
    end

    initial
    begin
        phi2 = 1'b0;
        forever #4 phi2 = ~phi2;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge phi2);
            cycle_count++;
        end
        $display("timeout: the program did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        r = lcg_state;
        return r[23:16];
    endfunction

    // one of the fifteen supported opcodes
    function automatic logic [7:0] pick_opcode(input logic [7:0] r);
        case (r % 8'd15)
            8'd0:    return 8'hA9;
            8'd1:    return 8'hA2;
            8'd2:    return 8'hA0;
            8'd3:    return 8'h09;
            8'd4:    return 8'h29;
            8'd5:    return 8'h49;
            8'd6:    return 8'h69;
            8'd7:    return 8'h4A;
            8'd8:    return 8'hAA;
            8'd9:    return 8'hA8;
            8'd10:   return 8'h8A;
            8'd11:   return 8'h98;
            8'd12:   return 8'h8D;
            8'd13:   return 8'h8E;
            default: return 8'h8C;
        endcase
    endfunction

    function automatic int instr_len(input logic [7:0] op);
        case (op)
            8'h8D, 8'h8E, 8'h8C:                             return 3;
            8'hA9, 8'hA2, 8'hA0, 8'h09, 8'h29, 8'h49, 8'h69: return 2;
            default:                                         return 1;
        endcase
    endfunction

    function automatic int instr_cycles(input logic [7:0] op);
        if (op == 8'h8D || op == 8'h8E || op == 8'h8C)
            return 4;
        return 2;
    endfunction

    function automatic logic [7:0] store_value(input logic [7:0] op);
        case (op)
            8'h8D:   return m_ac;
            8'h8E:   return m_x;
            default: return m_y;
        endcase
    endfunction

    // instruction semantics in 8 bits without carry
    task automatic apply_model(input logic [7:0] op, input logic [7:0] operand);
        case (op)
            8'hA9: m_ac = operand;
            8'hA2: m_x = operand;
            8'hA0: m_y = operand;
            8'h09: m_ac = m_ac | operand;
            8'h29: m_ac = m_ac & operand;
            8'h49: m_ac = m_ac ^ operand;
            8'h69: m_ac = m_ac + operand;
            8'h4A: m_ac = {1'b0, m_ac[7:1]};
            8'hAA: m_x = m_ac;
            8'hA8: m_y = m_ac;
            8'h8A: m_ac = m_x;
            8'h98: m_ac = m_y;
            default: ;
        endcase
    endtask

    task automatic build_program();
        logic [15:0] a;
        int i;
        for (i = 0; i < N_RANDOM; i++)
        begin
            prog_op[i] = pick_opcode(rand_byte());
            prog_lo[i] = rand_byte();
            // stores stay in page 30-3F away from the code
            prog_hi[i] = 8'h30 | (rand_byte() & 8'h0F);
        end
        prog_op[N_RANDOM]     = 8'h8D;
        prog_op[N_RANDOM + 1] = 8'h8E;
        prog_op[N_RANDOM + 2] = 8'h8C;
        prog_op[N_RANDOM + 3] = 8'hAA;
        for (i = N_RANDOM; i < N_PROG; i++)
        begin
            prog_lo[i] = 8'(i - N_RANDOM);
            prog_hi[i] = 8'h3F;
        end
        a = PROG_BASE;
        for (i = 0; i < N_PROG; i++)
        begin
            mem[a] = prog_op[i];
            if (instr_len(prog_op[i]) > 1)
                mem[a + 16'd1] = prog_lo[i];
            if (instr_len(prog_op[i]) > 2)
                mem[a + 16'd2] = prog_hi[i];
            a = a + 16'(instr_len(prog_op[i]));
        end
        // endless run of TAX after the program
        for (i = 0; i < 64; i++)
            mem[a + 16'(i)] = 8'hAA;
    endtask

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        test_checks++;
        if (actual !== expected)
        begin
            test_errors++;
            $display("FAIL time=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic begin_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    // entered in one fetch cycle and returns in the next
    task automatic run_instr(input int idx);
        logic [7:0]  op;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [15:0] pc0;
        logic        fetched;
        int          n;
        int          cyc;
        op = prog_op[idx];
        lo = prog_lo[idx];
        hi = prog_hi[idx];
        pc0 = m_pc;
        n = instr_cycles(op);
        check("o_addr", pc0, addr);
        check("o_rw", 16'd1, {15'd0, rw});
        cyc = 0;
        fetched = 1'b0;
        while (!fetched)
        begin
            @(negedge phi2);
            cyc++;
            if (sync === 1'b1)
                fetched = 1'b1;
            else if (n == 4 && cyc == 3)
            begin
                check("o_rw", 16'd0, {15'd0, rw});
                check("o_addr", {hi, lo}, addr);
                check("o_data", {8'h00, store_value(op)}, {8'h00, wr_data});
            end
            else
            begin
                check("o_rw", 16'd1, {15'd0, rw});
                if (cyc < n)
                    check("o_addr", pc0 + 16'(cyc), addr);
            end
        end
        check("fetch gap", 16'(n), 16'(cyc));
        m_pc = pc0 + 16'(instr_len(op));
        apply_model(op, lo);
    endtask

    initial
    begin : main
        logic [15:0] reset_addr [5];
        int k;
        rst_n = 1'b0;
        lcg_state = 32'd42;
        total_checks = 0;
        total_errors = 0;
        m_pc = PROG_BASE;
        m_ac = 8'h00;
        m_x = 8'h00;
        m_y = 8'h00;
        for (k = 0; k < 65536; k++)
            mem[k] = 8'(k) ^ 8'(k >> 8) ^ 8'h5A;
        mem[`CPU_RESET_VECTOR] = PROG_BASE[7:0];
        mem[`CPU_RESET_VECTOR + 16'd1] = PROG_BASE[15:8];
        build_program();

        reset_addr[0] = {`CPU_STACK_PAGE, `CPU_S_INIT};
        reset_addr[1] = {`CPU_STACK_PAGE, 8'(`CPU_S_INIT - 8'd1)};
        reset_addr[2] = {`CPU_STACK_PAGE, 8'(`CPU_S_INIT - 8'd2)};
        reset_addr[3] = `CPU_RESET_VECTOR;
        reset_addr[4] = `CPU_RESET_VECTOR + 16'd1;

        repeat (RESET_CYCLES) @(posedge phi2);
        #1 rst_n = 1'b1;

        // three stack reads, the vector, then the first fetch
        begin_test();
        for (k = 0; k < 5; k++)
        begin
            @(negedge phi2);
            check("o_sync", 16'd0, {15'd0, sync});
            check("o_rw", 16'd1, {15'd0, rw});
            check("o_addr", reset_addr[k], addr);
        end
        @(negedge phi2);
        check("o_sync", 16'd1, {15'd0, sync});
        check("o_addr", PROG_BASE, addr);
        end_test("reset_sequence");

        begin_test();
        for (k = 0; k < N_RANDOM; k++)
            run_instr(k);
        end_test("random_program");

        begin_test();
        for (k = N_RANDOM; k < N_RANDOM + 3; k++)
            run_instr(k);
        check("mem[3f00]", {8'h00, m_ac}, {8'h00, mem[16'h3F00]});
        check("mem[3f01]", {8'h00, m_x}, {8'h00, mem[16'h3F01]});
        check("mem[3f02]", {8'h00, m_y}, {8'h00, mem[16'h3F02]});
        run_instr(N_RANDOM + 3);
        end_test("closing_stores");

        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
cpu_pkg.sv
timing_gen.sv
decoder.sv
datapath.sv
alu.sv
cpu_top.sv
tb_cpu.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_cpu
FILELIST  := files.f
LINTFLAGS := --lint-only --timing --top-module $(TOP)
SIMFLAGS  := --binary --timing --top-module $(TOP) -Mdir obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
